// ==== hw/icache_pkg.sv ====
// Instruction cache definitions
`default_nettype none

package icache_pkg;

  // Address and instruction word widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;

  // Number of byte offset bits below the word offset
  localparam int unsigned BYTE_OFFSET_W = 2;

  // Byte address from the fetch stage, two low bits unused
  typedef logic [ADDR_W-1:0] addr_t;

  // One instruction word
  typedef logic [WORD_W-1:0] word_t;

  // Miss handling FSM of the controller
  typedef enum logic [1:0] {
    ICACHE_IDLE        = 2'b00,
    ICACHE_READ_MEMORY = 2'b01,
    ICACHE_FILL        = 2'b10
  } icache_state_e;

endpackage

`default_nettype wire

// ==== hw/icache_controller.sv ====
// Instruction cache controller
`timescale 1ns/100ps
`default_nettype none

module icache_controller #(
  parameter int unsigned SETS       = 16,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Lookup result from the tag array
  input  logic                cache_hit_i,
  input  logic                imem_sel_i,

  // Fetch stage side
  input  logic                if2icache_req_i,
  input  logic                if2icache_req_kill_i,
  input  icache_pkg::addr_t   if2icache_addr_i,
  input  logic                flush_i,
  output logic                icache2if_ack_o,

  // Instruction memory side
  input  logic                mem2icache_ack_i,
  output logic                icache2mem_req_o,
  output icache_pkg::addr_t   icache2mem_addr_o,

  // Array controls
  output logic                fill_en_o,
  output logic                lru_update_o,
  output logic                flush_en_o
);

  // Lowest address bit above the line offset
  localparam int unsigned LINE_LSB = icache_pkg::BYTE_OFFSET_W + $clog2(LINE_WORDS);

  // Both sizes must be powers of two for the address split
  if (((SETS & (SETS - 1)) != 0) || ((LINE_WORDS & (LINE_WORDS - 1)) != 0) ||
      (SETS < 2) || (LINE_WORDS < 2)) begin : gen_param_check
    $error("SETS and LINE_WORDS must be powers of two and at least 2");
  end

  icache_pkg::icache_state_e state_q, state_d;

  icache_pkg::addr_t line_addr;
  icache_pkg::addr_t miss_line_q;

  logic req_valid;
  logic abort;
  logic hit_accept;
  logic miss_start;
  logic mem_req;

  // Line aligned version of the fetch address
  assign line_addr = {if2icache_addr_i[icache_pkg::ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};

  // A request already answered this cycle is not taken again
  assign req_valid = if2icache_req_i & ~icache2if_ack_o;

  // Redirect or leaving the cacheable region drops everything
  assign abort = ~imem_sel_i | if2icache_req_kill_i;

  always_comb begin
    state_d    = state_q;
    mem_req    = 1'b0;
    fill_en_o  = 1'b0;
    flush_en_o = 1'b0;
    hit_accept = 1'b0;
    miss_start = 1'b0;

    unique case (state_q)
      icache_pkg::ICACHE_IDLE: begin
        // Flush takes priority, no answer this cycle
        if (flush_i) begin
          flush_en_o = 1'b1;
        end else if (req_valid && cache_hit_i) begin
          hit_accept = 1'b1;
        end else if (req_valid) begin
          // Miss, memory request goes out right away
          miss_start = 1'b1;
          mem_req    = 1'b1;
          state_d    = icache_pkg::ICACHE_READ_MEMORY;
        end
      end

      icache_pkg::ICACHE_READ_MEMORY: begin
        // Hold the request until memory answers
        mem_req = 1'b1;
        if (mem2icache_ack_i) begin
          state_d = icache_pkg::ICACHE_FILL;
        end
      end

      icache_pkg::ICACHE_FILL: begin
        // Line, tag, valid and LRU written here
        fill_en_o = 1'b1;
        state_d   = icache_pkg::ICACHE_IDLE;
      end

      default: begin
        state_d = icache_pkg::ICACHE_IDLE;
      end
    endcase

    // Kill overrides any state, late memory data is ignored
    if (abort) begin
      state_d    = icache_pkg::ICACHE_IDLE;
      mem_req    = 1'b0;
      fill_en_o  = 1'b0;
      hit_accept = 1'b0;
      miss_start = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q         <= icache_pkg::ICACHE_IDLE;
      icache2if_ack_o <= 1'b0;
    end else begin
      state_q         <= state_d;
      icache2if_ack_o <= hit_accept;
    end
  end

  // Line address of the outstanding miss
  always_ff @(posedge clk_i) begin
    if (miss_start) begin
      miss_line_q <= line_addr;
    end
  end

  assign icache2mem_req_o = mem_req;
  assign lru_update_o     = hit_accept;

  // Straight from the fetch address when the miss starts, then held
  assign icache2mem_addr_o = (state_q == icache_pkg::ICACHE_IDLE) ? line_addr : miss_line_q;

  // Memory address held for the whole transaction
  a_mem_addr_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (icache2mem_req_o && !mem2icache_ack_i) |=>
      (!icache2mem_req_o || $stable(icache2mem_addr_o))
  );

  // A held request is answered only once
  a_ack_single: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    icache2if_ack_o |=> !icache2if_ack_o
  );

  a_fill_in_fill_state: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fill_en_o |-> (state_q == icache_pkg::ICACHE_FILL)
  );

endmodule

`default_nettype wire

// ==== hw/icache_tag_array.sv ====
// Instruction cache tag array
`timescale 1ns/100ps
`default_nettype none

module icache_tag_array #(
  parameter int unsigned SETS       = 16,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               fill_en_i,
  input  logic               lru_update_i,
  input  logic               flush_en_i,
  input  icache_pkg::addr_t  lookup_addr_i,
  output logic               cache_hit_o,
  output logic               hit_way_o,
  output logic               victim_way_o
);

  localparam int unsigned OFFSET_W = $clog2(LINE_WORDS);
  localparam int unsigned INDEX_W  = $clog2(SETS);
  localparam int unsigned INDEX_LSB = icache_pkg::BYTE_OFFSET_W + OFFSET_W;
  localparam int unsigned TAG_LSB  = INDEX_LSB + INDEX_W;
  localparam int unsigned TAG_W    = icache_pkg::ADDR_W - TAG_LSB;

  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [TAG_W-1:0]   tag_t;

  // Tags per way and set
  tag_t tag_mem [2][SETS];

  // Valid bits per way, one bit per set
  logic [SETS-1:0] valid_q [2];

  // LRU bit names the least recently used way of a set
  logic [SETS-1:0] lru_q;

  index_t     index;
  tag_t       tag;
  logic [1:0] way_hit;

  assign index = lookup_addr_i[TAG_LSB-1:INDEX_LSB];
  assign tag   = lookup_addr_i[icache_pkg::ADDR_W-1:TAG_LSB];

  // Tag compare on both ways at once
  assign way_hit[0] = valid_q[0][index] && (tag_mem[0][index] == tag);
  assign way_hit[1] = valid_q[1][index] && (tag_mem[1][index] == tag);

  assign cache_hit_o = |way_hit;
  assign hit_way_o   = way_hit[1];

  // Invalid way first, way 0 before way 1, then the LRU way
  always_comb begin
    if (!valid_q[0][index]) begin
      victim_way_o = 1'b0;
    end else if (!valid_q[1][index]) begin
      victim_way_o = 1'b1;
    end else begin
      victim_way_o = lru_q[index];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      valid_q[0] <= '0;
      valid_q[1] <= '0;
      lru_q      <= '0;
    end else if (flush_en_i) begin
      // Fence drops every line at once
      valid_q[0] <= '0;
      valid_q[1] <= '0;
    end else if (fill_en_i) begin
      valid_q[victim_way_o][index] <= 1'b1;
      // The way not filled becomes LRU
      lru_q[index] <= ~victim_way_o;
    end else if (lru_update_i) begin
      lru_q[index] <= ~hit_way_o;
    end
  end

  // Tag storage
  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      tag_mem[victim_way_o][index] <= tag;
    end
  end

  // A line is never present in both ways of a set
  a_one_way_hits: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(way_hit[0] && way_hit[1])
  );

endmodule

`default_nettype wire

// ==== hw/icache_data_array.sv ====
// Instruction cache data array
`timescale 1ns/100ps
`default_nettype none

module icache_data_array #(
  parameter int unsigned SETS       = 16,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                                  clk_i,
  input  logic                                  fill_en_i,
  input  logic                                  hit_way_i,
  input  logic                                  victim_way_i,
  input  icache_pkg::addr_t                     lookup_addr_i,
  input  logic [LINE_WORDS*icache_pkg::WORD_W-1:0] fill_line_i,
  output icache_pkg::word_t                     rd_word_o
);

  localparam int unsigned OFFSET_W  = $clog2(LINE_WORDS);
  localparam int unsigned INDEX_W   = $clog2(SETS);
  localparam int unsigned OFFSET_LSB = icache_pkg::BYTE_OFFSET_W;
  localparam int unsigned INDEX_LSB = OFFSET_LSB + OFFSET_W;

  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [OFFSET_W-1:0] offset_t;

  // Word 0 sits in the low bits of a line
  typedef icache_pkg::word_t [LINE_WORDS-1:0] line_t;

  // Line storage, both ways
  line_t line_mem [2][SETS];

  index_t  index;
  offset_t offset;
  line_t   rd_line;

  assign index  = lookup_addr_i[INDEX_LSB+INDEX_W-1:INDEX_LSB];
  assign offset = lookup_addr_i[INDEX_LSB-1:OFFSET_LSB];

  // Whole line goes into the victim way
  always_ff @(posedge clk_i) begin
    if (fill_en_i) begin
      line_mem[victim_way_i][index] <= fill_line_i;
    end
  end

  // Hit way read, then word select by offset
  assign rd_line   = line_mem[hit_way_i][index];
  assign rd_word_o = rd_line[offset];

endmodule

`default_nettype wire

// ==== hw/icache_top.sv ====
// Instruction cache top level
`timescale 1ns/100ps
`default_nettype none

module icache_top #(
  parameter int unsigned SETS       = 16,
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,

  // Fetch stage
  input  logic                                     if2icache_req_i,
  input  logic                                     if2icache_req_kill_i,
  input  icache_pkg::addr_t                        if2icache_addr_i,
  input  logic                                     imem_sel_i,
  input  logic                                     flush_i,
  output logic                                     icache2if_ack_o,
  output icache_pkg::word_t                        icache2if_data_o,

  // Instruction memory
  input  logic                                     mem2icache_ack_i,
  input  logic [LINE_WORDS*icache_pkg::WORD_W-1:0] mem2icache_data_i,
  output logic                                     icache2mem_req_o,
  output icache_pkg::addr_t                        icache2mem_addr_o
);

  logic              cache_hit;
  logic              hit_way;
  logic              victim_way;
  logic              fill_en;
  logic              lru_update;
  logic              flush_en;
  icache_pkg::word_t rd_word;

  icache_controller #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) icache_controller_i (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .cache_hit_i          (cache_hit),
    .imem_sel_i           (imem_sel_i),
    .if2icache_req_i      (if2icache_req_i),
    .if2icache_req_kill_i (if2icache_req_kill_i),
    .if2icache_addr_i     (if2icache_addr_i),
    .flush_i              (flush_i),
    .icache2if_ack_o      (icache2if_ack_o),
    .mem2icache_ack_i     (mem2icache_ack_i),
    .icache2mem_req_o     (icache2mem_req_o),
    .icache2mem_addr_o    (icache2mem_addr_o),
    .fill_en_o            (fill_en),
    .lru_update_o         (lru_update),
    .flush_en_o           (flush_en)
  );

  icache_tag_array #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) icache_tag_array_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .fill_en_i     (fill_en),
    .lru_update_i  (lru_update),
    .flush_en_i    (flush_en),
    .lookup_addr_i (if2icache_addr_i),
    .cache_hit_o   (cache_hit),
    .hit_way_o     (hit_way),
    .victim_way_o  (victim_way)
  );

  // Memory data is written straight into the array in the fill cycle
  icache_data_array #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) icache_data_array_i (
    .clk_i         (clk_i),
    .fill_en_i     (fill_en),
    .hit_way_i     (hit_way),
    .victim_way_i  (victim_way),
    .lookup_addr_i (if2icache_addr_i),
    .fill_line_i   (mem2icache_data_i),
    .rd_word_o     (rd_word)
  );

  // Read word captured on a hit, lines up with the registered ack
  always_ff @(posedge clk_i) begin
    if (cache_hit) begin
      icache2if_data_o <= rd_word;
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_icache_mem.sv ====
// Instruction memory model
`timescale 1ns/100ps
`default_nettype none

module tb_icache_mem #(
  parameter int unsigned LINE_WORDS = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     req_i,
  input  icache_pkg::addr_t                        addr_i,
  output logic                                     ack_o,
  output logic [LINE_WORDS*icache_pkg::WORD_W-1:0] data_o,
  output int unsigned                              req_count_o
);

  logic        busy_q;
  logic        req_q;
  int unsigned wait_q;

  // Each word holds its word address XOR a fixed pattern
  function automatic logic [LINE_WORDS*icache_pkg::WORD_W-1:0] line_data(
    input icache_pkg::addr_t line_addr
  );
    logic [LINE_WORDS*icache_pkg::WORD_W-1:0] line;
    logic [31:0]                              word_addr;
    line = '0;
    for (int i = 0; i < LINE_WORDS; i++) begin
      word_addr = {2'b00, line_addr[31:2]} + 32'(i);
      line[i*icache_pkg::WORD_W +: icache_pkg::WORD_W] = word_addr ^ 32'hA5A5_0000;
    end
    return line;
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      req_q       <= 1'b0;
      wait_q      <= 0;
      ack_o       <= 1'b0;
      data_o      <= '0;
      req_count_o <= 0;
    end else begin
      req_q <= req_i;
      ack_o <= 1'b0;
      // Rising edge of the request starts a transaction
      if (req_i && !req_q) begin
        req_count_o <= req_count_o + 1;
      end
      if (busy_q && !req_i) begin
        // Request dropped by a kill, transaction ends
        busy_q <= 1'b0;
      end else if (busy_q) begin
        if (wait_q == 1) begin
          // Data stays put after the ack, the cache fills one cycle later
          ack_o  <= 1'b1;
          data_o <= line_data(addr_i);
          busy_q <= 1'b0;
        end else begin
          wait_q <= wait_q - 1;
        end
      end else if (req_i && !ack_o) begin
        busy_q <= 1'b1;
        wait_q <= 1 + ($urandom % 8);
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/tb_icache.sv ====
// Instruction cache testbench
`timescale 1ns/100ps
`default_nettype none

module tb_icache;

  localparam int unsigned SETS          = 16;
  localparam int unsigned LINE_WORDS    = 4;
  localparam int unsigned LINE_BITS     = LINE_WORDS * icache_pkg::WORD_W;
  localparam int unsigned RESET_CYCLES  = 16;
  localparam int unsigned FETCH_TIMEOUT = 100;
  localparam int unsigned REQ_TIMEOUT   = 20;
  localparam int unsigned QUIET_WINDOW  = 20;
  // Request in cycle t, ack in cycle t+1, seen at the edge that closes t+1
  localparam int unsigned HIT_LATENCY   = 2;
  localparam logic [31:0] SEED          = 32'h1ecd_edd9;

  logic                    clk;
  logic                    rst_n;
  logic                    if2icache_req;
  logic                    if2icache_req_kill;
  icache_pkg::addr_t       if2icache_addr;
  logic                    imem_sel;
  logic                    flush;
  logic                    icache2if_ack;
  icache_pkg::word_t       icache2if_data;
  logic                    mem2icache_ack;
  logic [LINE_BITS-1:0]    mem2icache_data;
  logic                    icache2mem_req;
  icache_pkg::addr_t       icache2mem_addr;
  int unsigned             mem_req_count;
  int unsigned             error_count;
  int unsigned             check_count;
  int unsigned             seed_value;

  icache_top #(
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) icache_top_i (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .if2icache_req_i      (if2icache_req),
    .if2icache_req_kill_i (if2icache_req_kill),
    .if2icache_addr_i     (if2icache_addr),
    .imem_sel_i           (imem_sel),
    .flush_i              (flush),
    .icache2if_ack_o      (icache2if_ack),
    .icache2if_data_o     (icache2if_data),
    .mem2icache_ack_i     (mem2icache_ack),
    .mem2icache_data_i    (mem2icache_data),
    .icache2mem_req_o     (icache2mem_req),
    .icache2mem_addr_o    (icache2mem_addr)
  );

  tb_icache_mem #(
    .LINE_WORDS (LINE_WORDS)
  ) mem_model_i (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (icache2mem_req),
    .addr_i      (icache2mem_addr),
    .ack_o       (mem2icache_ack),
    .data_o      (mem2icache_data),
    .req_count_o (mem_req_count)
  );

  always #4 clk = ~clk;

  // Expected instruction at a byte address
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t addr);
    logic [31:0] word_addr;
    word_addr = {2'b00, addr[31:2]};
    return word_addr ^ 32'hA5A5_0000;
  endfunction

  // Byte address of the first word of the line holding an address
  function automatic icache_pkg::addr_t line_address(input icache_pkg::addr_t addr);
    return addr & ~32'(LINE_WORDS * 4 - 1);
  endfunction

  task automatic check_value(input string test_name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual) begin
      $display("[FAIL] %s: expected %h, actual %h", test_name, expected, actual);
      error_count++;
    end
  endtask

  // Request, wait for the ack, compare the word
  task automatic fetch(input string test_name, input icache_pkg::addr_t addr,
                       output int unsigned latency);
    int unsigned cycles;
    logic        done;
    cycles = 0;
    done   = 1'b0;
    @(posedge clk);
    if2icache_req  <= 1'b1;
    if2icache_addr <= addr;
    while (!done && cycles < FETCH_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      // A miss asks memory for the line holding the address
      if (icache2mem_req) begin
        check_value({test_name, " memory address"}, line_address(addr), icache2mem_addr);
      end
      done = icache2if_ack;
    end
    // Request may drop in the ack cycle
    if2icache_req <= 1'b0;
    latency = cycles;
    if (done) begin
      check_value(test_name, expected_word(addr), icache2if_data);
    end else begin
      $display("Timeout in %s: no acknowledge for address %h after %0d cycles",
               test_name, addr, cycles);
      error_count++;
    end
  endtask

  // Fetch and check how many new memory requests it caused
  task automatic fetch_and_count(input string test_name, input icache_pkg::addr_t addr,
                                 input int unsigned exp_requests);
    int unsigned count_before;
    int unsigned latency;
    count_before = mem_req_count;
    fetch(test_name, addr, latency);
    check_value({test_name, " memory requests"}, count_before + exp_requests, mem_req_count);
  endtask

  task automatic test_miss_then_hit();
    int unsigned count_before;
    int unsigned latency;
    fetch_and_count("miss_then_hit cold", 32'h0000_0110, 1);
    count_before = mem_req_count;
    fetch("miss_then_hit warm", 32'h0000_0114, latency);
    check_value("miss_then_hit memory requests", count_before, mem_req_count);
    check_value("miss_then_hit ack latency", HIT_LATENCY, latency);
  endtask

  task automatic test_whole_line();
    int unsigned count_before;
    int unsigned latency;
    count_before = mem_req_count;
    for (int i = 0; i < LINE_WORDS; i++) begin
      fetch("whole_line", 32'h0000_0520 + 32'(4 * i), latency);
    end
    // Only the first word misses
    check_value("whole_line memory requests", count_before + 1, mem_req_count);
  endtask

  task automatic test_lru_replace();
    // Three tags that all map to set 4
    fetch_and_count("lru A miss", 32'h0000_1040, 1);
    fetch_and_count("lru B miss", 32'h0000_2044, 1);
    fetch_and_count("lru A hit", 32'h0000_1048, 0);
    fetch_and_count("lru C miss", 32'h0000_304c, 1);
    fetch_and_count("lru A still hit", 32'h0000_1044, 0);
    fetch_and_count("lru B evicted", 32'h0000_2040, 1);
  endtask

  task automatic test_kill_refill();
    int unsigned count_before;
    int unsigned cycles;
    logic        seen;
    logic        dropped;
    count_before = mem_req_count;
    cycles       = 0;
    seen         = 1'b0;
    @(posedge clk);
    if2icache_req  <= 1'b1;
    if2icache_addr <= 32'h0000_0668;
    while (!seen && cycles < REQ_TIMEOUT) begin
      @(posedge clk);
      cycles++;
      seen = icache2mem_req;
    end
    if (!seen) begin
      $display("Kill test: the miss raised no memory request");
      error_count++;
    end
    // Redirect while the refill is outstanding
    if2icache_req_kill <= 1'b1;
    if2icache_req      <= 1'b0;
    @(posedge clk);
    if2icache_req_kill <= 1'b0;
    cycles  = 1;
    dropped = !icache2mem_req;
    while (!dropped && cycles < 2) begin
      @(posedge clk);
      cycles++;
      dropped = !icache2mem_req;
    end
    if (!dropped) begin
      $display("Kill test: memory request still high two cycles after the kill");
      error_count++;
    end
    // The killed request must never be answered
    for (int i = 0; i < QUIET_WINDOW; i++) begin
      @(posedge clk);
      if (icache2if_ack) begin
        $display("Kill test: acknowledge given for a killed request");
        error_count++;
      end
    end
    check_value("kill memory requests", count_before + 1, mem_req_count);
    fetch_and_count("kill refetch", 32'h0000_0668, 1);
  endtask

  task automatic test_uncacheable();
    int unsigned count_before;
    count_before = mem_req_count;
    @(posedge clk);
    imem_sel       <= 1'b0;
    if2icache_req  <= 1'b1;
    if2icache_addr <= 32'h0000_0770;
    for (int i = 0; i < QUIET_WINDOW; i++) begin
      @(posedge clk);
      if (icache2if_ack || icache2mem_req) begin
        $display("Uncacheable test: cache reacted to a request outside its region");
        error_count++;
      end
    end
    if2icache_req <= 1'b0;
    imem_sel      <= 1'b1;
    check_value("uncacheable memory requests", count_before, mem_req_count);
    fetch_and_count("uncacheable then cached", 32'h0000_0770, 1);
  endtask

  task automatic test_flush();
    fetch_and_count("flush before set 1", 32'h0000_0110, 0);
    fetch_and_count("flush before set 2", 32'h0000_0524, 0);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    // All lines gone, both addresses refill
    fetch_and_count("flush after set 1", 32'h0000_0110, 1);
    fetch_and_count("flush after set 2", 32'h0000_0524, 1);
  endtask

  initial begin
    seed_value         = $urandom(SEED);
    error_count        = 0;
    check_count        = 0;
    clk                = 1'b0;
    rst_n              = 1'b0;
    if2icache_req      = 1'b0;
    if2icache_req_kill = 1'b0;
    if2icache_addr     = '0;
    imem_sel           = 1'b1;
    flush              = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    test_miss_then_hit();
    test_whole_line();
    test_lru_replace();
    test_kill_refill();
    test_uncacheable();
    test_flush();
    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
hw/icache_pkg.sv
hw/icache_controller.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_top.sv
dv/tb_icache_mem.sv
dv/tb_icache.sv

// ==== Makefile ====
# Verilator build for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the simulation prints the pass line
run: compile
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
